// File: hdl/stq_pkg.sv
////////////////////////////////////////////////////////////
// shared address, mask and access size types for the store
// queue, plus the byte-mask function
////////////////////////////////////////////////////////////
`default_nettype none

package stq_pkg;

  localparam int addr_width = 32;

  // byte address without the two offset bits
  typedef logic [addr_width-3:0] word_addr_t;

  // one bit per byte lane of a 32-bit word
  typedef logic [3:0] byte_mask_t;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  // lanes touched by an aligned access
  function automatic byte_mask_t byte_mask_of(
    input access_size_e size,
    input logic [1:0] low
  );
    byte_mask_t mask;
    case (size)
      size_byte: mask = 4'b0001 << low;
      size_half: mask = 4'b0011 << low;
      default:   mask = 4'b1111;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: hdl/stq_alloc.sv
////////////////////////////////////////////////////////////
// store queue allocator: tail tag with wrap bit, full/empty
////////////////////////////////////////////////////////////
`default_nettype none

module stq_alloc #(
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       alloc_en,
  input  logic                       flush,
  input  logic [$clog2(depth):0]     head,
  output logic [$clog2(depth):0]     tail,
  output logic                       full,
  output logic                       empty
);

  localparam int iw = $clog2(depth);
  localparam int tw = iw + 1;

  logic [tw-1:0] tail_next;

  assign tail_next = tail + tw'(1);

  // same slot index, wrap bits apart by one lap
  assign full  = (tail[iw-1:0] == head[iw-1:0]) && (tail[iw] != head[iw]);
  assign empty = (tail == head);

  always_ff @(posedge clk) begin
    if (rst) begin
      tail <= '0;
    end else if (flush) begin
      // drop every uncommitted store
      tail <= head;
    end else if (alloc_en) begin
      tail <= tail_next;
    end
  end

  // full depends on the head held by the commit side
  a_no_alloc_full: assert property (
    @(posedge clk) disable iff (rst) alloc_en |-> !full
  );

  a_no_flush_alloc: assert property (
    @(posedge clk) disable iff (rst) !(flush && alloc_en)
  );

endmodule

`default_nettype wire

// File: hdl/stq_entry_array.sv
////////////////////////////////////////////////////////////
// store queue slots: address, size, byte mask, known bit
////////////////////////////////////////////////////////////
`default_nettype none

module stq_entry_array #(
  parameter int depth = 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  alloc_en,
  input  logic [$clog2(depth):0]                tail,
  input  logic                                  wrt_en,
  input  logic [$clog2(depth):0]                wrt_tag,
  input  logic [stq_pkg::addr_width-1:0]        wrt_addr,
  input  stq_pkg::access_size_e                 wrt_size,
  input  logic [$clog2(depth):0]                head,
  output stq_pkg::word_addr_t [depth-1:0]       slot_word,
  output stq_pkg::byte_mask_t [depth-1:0]       slot_mask,
  output logic [depth-1:0]                      slot_known,
  output logic [stq_pkg::addr_width-1:0]        head_addr,
  output stq_pkg::access_size_e                 head_size,
  output logic                                  head_known
);

  localparam int iw = $clog2(depth);
  localparam int tw = iw + 1;

  logic [iw-1:0] tail_idx;
  logic [iw-1:0] wrt_idx;
  logic [iw-1:0] head_idx;

  // byte offset and size kept only for the commit read port
  logic [depth-1:0][1:0] low_q;
  stq_pkg::access_size_e size_q [depth];

  // distance from head, used to place a write inside the queue
  logic [tw-1:0] wrt_age;
  logic [tw-1:0] occupancy;

  assign tail_idx = tail[iw-1:0];
  assign wrt_idx  = wrt_tag[iw-1:0];
  assign head_idx = head[iw-1:0];

  assign wrt_age   = wrt_tag - head;
  assign occupancy = tail - head;

  always_ff @(posedge clk) begin
    if (wrt_en) begin
      slot_word[wrt_idx] <= wrt_addr[stq_pkg::addr_width-1:2];
      low_q[wrt_idx]     <= wrt_addr[1:0];
      size_q[wrt_idx]    <= wrt_size;
      slot_mask[wrt_idx] <= stq_pkg::byte_mask_of(wrt_size, wrt_addr[1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_known <= '0;
    end else begin
      // a fresh slot has no address yet
      if (alloc_en) begin
        slot_known[tail_idx] <= 1'b0;
      end
      if (wrt_en) begin
        slot_known[wrt_idx] <= 1'b1;
      end
    end
  end

  // head slot read port for commit
  assign head_addr  = {slot_word[head_idx], low_q[head_idx]};
  assign head_size  = size_q[head_idx];
  assign head_known = slot_known[head_idx];

  // accesses never cross a 4-byte word
  a_wrt_aligned: assert property (
    @(posedge clk) disable iff (rst)
    wrt_en |-> (wrt_size == stq_pkg::size_byte) ||
               (wrt_size == stq_pkg::size_half && !wrt_addr[0]) ||
               (wrt_size == stq_pkg::size_word && wrt_addr[1:0] == 2'b00)
  );

  // an address only goes to a store allocated on an earlier cycle
  a_wrt_in_queue: assert property (
    @(posedge clk) disable iff (rst) wrt_en |-> wrt_age < occupancy
  );

endmodule

`default_nettype wire

// File: hdl/stq_load_check.sv
////////////////////////////////////////////////////////////
// load check against older stores: overlap, youngest match,
// forwardability and unknown-address flag
////////////////////////////////////////////////////////////
`default_nettype none

module stq_load_check #(
  parameter int depth = 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  chk_en,
  input  logic [stq_pkg::addr_width-1:0]        chk_addr,
  input  stq_pkg::access_size_e                 chk_size,
  input  logic [$clog2(depth):0]                chk_tag,
  input  logic [$clog2(depth):0]                head,
  input  stq_pkg::word_addr_t [depth-1:0]       slot_word,
  input  stq_pkg::byte_mask_t [depth-1:0]       slot_mask,
  input  logic [depth-1:0]                      slot_known,
  output logic                                  chk_done,
  output logic                                  chk_hit,
  output logic                                  chk_fwd,
  output logic                                  chk_unknown,
  output logic [$clog2(depth):0]                chk_store_tag
);

  localparam int iw = $clog2(depth);
  localparam int tw = iw + 1;

  logic [iw-1:0]       head_idx;
  logic [iw-1:0]       chk_idx;
  logic                same_wrap;
  stq_pkg::word_addr_t ld_word;
  stq_pkg::byte_mask_t ld_mask;

  logic [depth-1:0] ge_head;
  logic [depth-1:0] lt_chk;
  logic [depth-1:0] older;
  logic [depth-1:0] match;
  logic [depth-1:0] part_a;
  logic [depth-1:0] part_b;

  logic          has_a;
  logic          has_b;
  logic [iw-1:0] idx_a;
  logic [iw-1:0] idx_b;
  logic [iw-1:0] idx_y;
  logic [tw-1:0] tag_y;
  logic          hit;
  logic          fwd;
  logic          unknown;

  // highest set index, i.e. youngest within one half
  function automatic logic [iw-1:0] last_set(input logic [depth-1:0] bits);
    logic [iw-1:0] idx;
    idx = '0;
    for (int i = 0; i < depth; i++) begin
      if (bits[i]) begin
        idx = iw'(i);
      end
    end
    return idx;
  endfunction

  assign head_idx  = head[iw-1:0];
  assign chk_idx   = chk_tag[iw-1:0];
  assign same_wrap = (head[iw] == chk_tag[iw]);
  assign ld_word   = chk_addr[stq_pkg::addr_width-1:2];
  assign ld_mask   = stq_pkg::byte_mask_of(chk_size, chk_addr[1:0]);

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      ge_head[i] = (iw'(i) >= head_idx);
      lt_chk[i]  = (iw'(i) < chk_idx);
    end
  end

  // older range is one run, or two runs when it crosses the wrap
  assign older = same_wrap ? (ge_head & lt_chk) : (ge_head | lt_chk);

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      match[i] = older[i] && slot_known[i] && (slot_word[i] == ld_word) &&
                 ((slot_mask[i] & ld_mask) != '0);
    end
  end

  // slots below chk_tag are always the younger half
  assign part_a = match & lt_chk;
  assign part_b = match & ~lt_chk;
  assign has_a  = |part_a;
  assign has_b  = |part_b;
  assign idx_a  = last_set(part_a);
  assign idx_b  = last_set(part_b);

  assign idx_y = has_a ? idx_a : idx_b;
  assign tag_y = {has_a ? chk_tag[iw] : head[iw], idx_y};

  assign hit     = has_a || has_b;
  assign fwd     = hit && ((slot_mask[idx_y] & ld_mask) == ld_mask);
  assign unknown = |(older & ~slot_known);

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_done <= 1'b0;
    end else begin
      chk_done <= chk_en;
    end
  end

  // results sampled at the chk_en edge, one per check
  always_ff @(posedge clk) begin
    if (chk_en) begin
      chk_hit       <= hit;
      chk_fwd       <= fwd;
      chk_unknown   <= unknown;
      chk_store_tag <= tag_y;
    end
  end

endmodule

`default_nettype wire

// File: hdl/stq_commit.sv
////////////////////////////////////////////////////////////
// in-order commit: head tag, readiness, registered output
////////////////////////////////////////////////////////////
`default_nettype none

module stq_commit #(
  parameter int depth = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              commit_en,
  input  logic                              flush,
  input  logic [$clog2(depth):0]            tail,
  input  logic [stq_pkg::addr_width-1:0]    head_addr,
  input  stq_pkg::access_size_e             head_size,
  input  logic                              head_known,
  output logic [$clog2(depth):0]            head,
  output logic                              commit_ready,
  output logic                              commit_done,
  output logic [stq_pkg::addr_width-1:0]    commit_addr,
  output stq_pkg::access_size_e             commit_size,
  output logic [$clog2(depth):0]            commit_tag
);

  localparam int tw = $clog2(depth) + 1;

  // oldest store present and its address resolved
  assign commit_ready = (head != tail) && head_known;

  always_ff @(posedge clk) begin
    if (rst) begin
      head        <= '0;
      commit_done <= 1'b0;
    end else begin
      commit_done <= commit_en;
      if (commit_en) begin
        head <= head + tw'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit_en) begin
      commit_addr <= head_addr;
      commit_size <= head_size;
      commit_tag  <= head;
    end
  end

  // readiness comes from the allocator tail and the slot array
  a_commit_ready: assert property (
    @(posedge clk) disable iff (rst) commit_en |-> commit_ready
  );

  a_no_flush_commit: assert property (
    @(posedge clk) disable iff (rst) !(flush && commit_en)
  );

endmodule

`default_nettype wire

// File: hdl/stq_top.sv
////////////////////////////////////////////////////////////
// store queue top: allocator, slot array, load check, commit
////////////////////////////////////////////////////////////
`default_nettype none

module stq_top #(
  parameter int depth = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              alloc_en,
  input  logic                              wrt_en,
  input  logic [$clog2(depth):0]            wrt_tag,
  input  logic [stq_pkg::addr_width-1:0]    wrt_addr,
  input  stq_pkg::access_size_e             wrt_size,
  input  logic                              chk_en,
  input  logic [stq_pkg::addr_width-1:0]    chk_addr,
  input  stq_pkg::access_size_e             chk_size,
  input  logic [$clog2(depth):0]            chk_tag,
  input  logic                              commit_en,
  input  logic                              flush,
  output logic [$clog2(depth):0]            alloc_tag,
  output logic                              full,
  output logic                              empty,
  output logic                              chk_done,
  output logic                              chk_hit,
  output logic                              chk_fwd,
  output logic                              chk_unknown,
  output logic [$clog2(depth):0]            chk_store_tag,
  output logic                              commit_ready,
  output logic                              commit_done,
  output logic [stq_pkg::addr_width-1:0]    commit_addr,
  output stq_pkg::access_size_e             commit_size,
  output logic [$clog2(depth):0]            commit_tag
);

  localparam int tw = $clog2(depth) + 1;

  logic [tw-1:0]                       tail;
  logic [tw-1:0]                       head;
  stq_pkg::word_addr_t [depth-1:0]     slot_word;
  stq_pkg::byte_mask_t [depth-1:0]     slot_mask;
  logic [depth-1:0]                    slot_known;
  logic [stq_pkg::addr_width-1:0]      head_addr;
  stq_pkg::access_size_e               head_size;
  logic                                head_known;

  // next store gets the current tail
  assign alloc_tag = tail;

  stq_alloc #(.depth(depth)) u_alloc (
    .clk      (clk),
    .rst      (rst),
    .alloc_en (alloc_en),
    .flush    (flush),
    .head     (head),
    .tail     (tail),
    .full     (full),
    .empty    (empty)
  );

  stq_entry_array #(.depth(depth)) u_array (
    .clk        (clk),
    .rst        (rst),
    .alloc_en   (alloc_en),
    .tail       (tail),
    .wrt_en     (wrt_en),
    .wrt_tag    (wrt_tag),
    .wrt_addr   (wrt_addr),
    .wrt_size   (wrt_size),
    .head       (head),
    .slot_word  (slot_word),
    .slot_mask  (slot_mask),
    .slot_known (slot_known),
    .head_addr  (head_addr),
    .head_size  (head_size),
    .head_known (head_known)
  );

  stq_load_check #(.depth(depth)) u_check (
    .clk           (clk),
    .rst           (rst),
    .chk_en        (chk_en),
    .chk_addr      (chk_addr),
    .chk_size      (chk_size),
    .chk_tag       (chk_tag),
    .head          (head),
    .slot_word     (slot_word),
    .slot_mask     (slot_mask),
    .slot_known    (slot_known),
    .chk_done      (chk_done),
    .chk_hit       (chk_hit),
    .chk_fwd       (chk_fwd),
    .chk_unknown   (chk_unknown),
    .chk_store_tag (chk_store_tag)
  );

  stq_commit #(.depth(depth)) u_commit (
    .clk          (clk),
    .rst          (rst),
    .commit_en    (commit_en),
    .flush        (flush),
    .tail         (tail),
    .head_addr    (head_addr),
    .head_size    (head_size),
    .head_known   (head_known),
    .head         (head),
    .commit_ready (commit_ready),
    .commit_done  (commit_done),
    .commit_addr  (commit_addr),
    .commit_size  (commit_size),
    .commit_tag   (commit_tag)
  );

endmodule

`default_nettype wire

// File: dv/stq_tb.sv
////////////////////////////////////////////////////////////
// store queue testbench with shadow model, expected result
// function and compare process
////////////////////////////////////////////////////////////
`default_nettype none

module stq_tb;

  localparam int depth = 8;
  localparam int tw = $clog2(depth) + 1;
  localparam int drain_limit = 50;

  typedef struct packed {
    logic [tw-1:0] tag;
    logic [31:0]   addr;
    logic [1:0]    size;
    logic          known;
  } store_rec_t;

  typedef struct packed {
    logic          hit;
    logic          fwd;
    logic          unk;
    logic [tw-1:0] stag;
    logic [31:0]   due;
  } chk_exp_t;

  typedef struct packed {
    logic [31:0]   addr;
    logic [1:0]    size;
    logic [tw-1:0] tag;
    logic [31:0]   due;
  } com_exp_t;

  logic                  clk;
  logic                  rst;
  logic                  alloc_en;
  logic                  wrt_en;
  logic [tw-1:0]         wrt_tag;
  logic [31:0]           wrt_addr;
  stq_pkg::access_size_e wrt_size;
  logic                  chk_en;
  logic [31:0]           chk_addr;
  stq_pkg::access_size_e chk_size;
  logic [tw-1:0]         chk_tag;
  logic                  commit_en;
  logic                  flush;
  logic [tw-1:0]         alloc_tag;
  logic                  full;
  logic                  empty;
  logic                  chk_done;
  logic                  chk_hit;
  logic                  chk_fwd;
  logic                  chk_unknown;
  logic [tw-1:0]         chk_store_tag;
  logic                  commit_ready;
  logic                  commit_done;
  logic [31:0]           commit_addr;
  stq_pkg::access_size_e commit_size;
  logic [tw-1:0]         commit_tag;

  // shadow queue with the oldest store first
  store_rec_t    sq[$];
  chk_exp_t      chk_q[$];
  com_exp_t      com_q[$];
  chk_exp_t      got_chk;
  com_exp_t      got_com;
  logic [tw-1:0] m_head;
  logic [tw-1:0] m_tail;
  logic [31:0]   flushed_addr;
  int            seed;
  int            cyc;
  int            errors;
  int            checks;
  int            test_err0;
  int            k;
  int            allocs;
  string         cur_test;

  stq_top #(.depth(depth)) uut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] low);
    logic [3:0] m;
    if (size == 2'd0) begin
      m = 4'b0001 << low;
    end else if (size == 2'd1) begin
      m = 4'b0011 << low;
    end else begin
      m = 4'b1111;
    end
    return m;
  endfunction

  // youngest overlapping store among those older than ctag
  function automatic chk_exp_t predict_load(input logic [31:0] addr, input logic [1:0] size,
                                            input logic [tw-1:0] ctag);
    chk_exp_t      r;
    logic [tw-1:0] n_older;
    logic [3:0]    ld_mask;
    logic [3:0]    st_mask;
    r = '0;
    n_older = ctag - m_head;
    ld_mask = lane_mask(size, addr[1:0]);
    for (int i = 0; i < n_older; i++) begin
      if (!sq[i].known) begin
        r.unk = 1'b1;
      end else if (sq[i].addr[31:2] == addr[31:2]) begin
        st_mask = lane_mask(sq[i].size, sq[i].addr[1:0]);
        if ((st_mask & ld_mask) != 4'b0000) begin
          r.hit  = 1'b1;
          r.stag = sq[i].tag;
          r.fwd  = ((st_mask & ld_mask) == ld_mask);
        end
      end
    end
    return r;
  endfunction

  function automatic int pick_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // aligned address within four neighbouring words
  function automatic logic [31:0] aligned_addr(input logic [1:0] size);
    logic [1:0] low;
    low = 2'(pick_below(4));
    if (size == 2'd1) begin
      low[0] = 1'b0;
    end else if (size == 2'd2) begin
      low = 2'b00;
    end
    return 32'h0000_4000 + 32'(pick_below(4) * 4) + 32'(low);
  endfunction

  task automatic compare_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic alloc_store();
    store_rec_t rec;
    compare_val("alloc_tag", m_tail, alloc_tag);
    compare_val("full", sq.size() == depth, full);
    alloc_en = 1'b1;
    @(negedge clk);
    alloc_en = 1'b0;
    rec = '0;
    rec.tag = m_tail;
    sq.push_back(rec);
    m_tail = m_tail + 1'b1;
  endtask

  task automatic write_store_addr(input int idx);
    store_rec_t rec;
    rec = sq[idx];
    rec.size = 2'(pick_below(3));
    rec.addr = aligned_addr(rec.size);
    rec.known = 1'b1;
    wrt_en = 1'b1;
    wrt_tag = rec.tag;
    wrt_addr = rec.addr;
    wrt_size = stq_pkg::access_size_e'(rec.size);
    @(negedge clk);
    wrt_en = 1'b0;
    sq[idx] = rec;
  endtask

  // an unknown head store is resolved first so readiness is seen both ways
  task automatic commit_oldest();
    com_exp_t   e;
    store_rec_t rec;
    if (!sq[0].known) begin
      compare_val("commit_ready", 0, commit_ready);
      write_store_addr(0);
    end
    compare_val("commit_ready", 1, commit_ready);
    rec = sq.pop_front();
    e.addr = rec.addr;
    e.size = rec.size;
    e.tag = rec.tag;
    e.due = cyc + 1;
    com_q.push_back(e);
    commit_en = 1'b1;
    @(negedge clk);
    commit_en = 1'b0;
    m_head = m_head + 1'b1;
  endtask

  task automatic issue_load(input logic [1:0] size, input logic [31:0] addr,
                            input logic [tw-1:0] ctag);
    chk_exp_t e;
    e = predict_load(addr, size, ctag);
    e.due = cyc + 1;
    chk_q.push_back(e);
    chk_en = 1'b1;
    chk_addr = addr;
    chk_size = stq_pkg::access_size_e'(size);
    chk_tag = ctag;
    @(negedge clk);
    chk_en = 1'b0;
  endtask

  task automatic random_load();
    logic [1:0]    size;
    logic [tw-1:0] ctag;
    size = 2'(pick_below(3));
    ctag = m_head + tw'(pick_below(sq.size() + 1));
    issue_load(size, aligned_addr(size), ctag);
  endtask

  task automatic flush_queue();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    sq.delete();
    m_tail = m_head;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    int n;
    n = 0;
    while ((chk_q.size() != 0 || com_q.size() != 0) && n < drain_limit) begin
      @(negedge clk);
      n++;
    end
    if (chk_q.size() != 0 || com_q.size() != 0) begin
      $display("%s timed out with %0d load results and %0d commits still missing",
               cur_test, chk_q.size(), com_q.size());
      errors++;
      chk_q.delete();
      com_q.delete();
    end
    if (errors == test_err0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_err0);
    end
  endtask

  // each done pulse is matched against the oldest pending expectation
  always @(negedge clk) begin
    if (!rst && chk_done) begin
      if (chk_q.size() == 0) begin
        $display("%s: load check result came with no load check pending", cur_test);
        errors++;
      end else begin
        got_chk = chk_q.pop_front();
        compare_val("chk_done cycle", got_chk.due, cyc);
        compare_val("chk_hit", got_chk.hit, chk_hit);
        compare_val("chk_fwd", got_chk.fwd, chk_fwd);
        compare_val("chk_unknown", got_chk.unk, chk_unknown);
        if (got_chk.hit) begin
          compare_val("chk_store_tag", got_chk.stag, chk_store_tag);
        end
      end
    end
    if (!rst && commit_done) begin
      if (com_q.size() == 0) begin
        $display("%s: commit result came with no commit pending", cur_test);
        errors++;
      end else begin
        got_com = com_q.pop_front();
        compare_val("commit_done cycle", got_com.due, cyc);
        compare_val("commit_addr", got_com.addr, commit_addr);
        compare_val("commit_size", got_com.size, commit_size);
        compare_val("commit_tag", got_com.tag, commit_tag);
      end
    end
  end

  initial begin
    seed = 92;
    cyc = 0;
    errors = 0;
    checks = 0;
    clk = 1'b0;
    rst = 1'b1;
    alloc_en = 1'b0;
    wrt_en = 1'b0;
    wrt_tag = '0;
    wrt_addr = '0;
    wrt_size = stq_pkg::size_byte;
    chk_en = 1'b0;
    chk_addr = '0;
    chk_size = stq_pkg::size_byte;
    chk_tag = '0;
    commit_en = 1'b0;
    flush = 1'b0;
    m_head = '0;
    m_tail = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    start_test("reset");
    compare_val("empty", 1, empty);
    compare_val("full", 0, full);
    compare_val("commit_ready", 0, commit_ready);
    compare_val("chk_done", 0, chk_done);
    compare_val("commit_done", 0, commit_done);
    finish_test();

    start_test("alloc_order");
    for (int i = 0; i < depth; i++) begin
      alloc_store();
      compare_val("empty", 0, empty);
    end
    compare_val("full", 1, full);
    compare_val("alloc_tag", m_tail, alloc_tag);
    for (int i = 0; i < depth; i++) begin
      write_store_addr(i);
    end
    while (sq.size() != 0) begin
      commit_oldest();
    end
    compare_val("empty", 1, empty);
    finish_test();

    // slot 2 stays unknown so commit later has to wait for it
    start_test("load_check");
    for (int i = 0; i < 6; i++) begin
      alloc_store();
    end
    for (int i = 0; i < 6; i++) begin
      if (i != 2 && pick_below(4) != 0) begin
        write_store_addr(i);
      end
    end
    for (int i = 0; i < 24; i++) begin
      random_load();
    end
    finish_test();

    start_test("commit");
    while (sq.size() != 0) begin
      commit_oldest();
    end
    finish_test();

    start_test("flush");
    for (int i = 0; i < 3; i++) begin
      alloc_store();
    end
    write_store_addr(0);
    write_store_addr(1);
    flushed_addr = sq[0].addr;
    flush_queue();
    compare_val("empty", 1, empty);
    compare_val("alloc_tag", m_head, alloc_tag);
    issue_load(2'd2, {flushed_addr[31:2], 2'b00}, m_head);
    finish_test();

    start_test("wrap");
    allocs = 0;
    for (int it = 0; it < 40 && allocs < 40; it++) begin
      k = 1 + pick_below(depth - sq.size());
      for (int i = 0; i < k; i++) begin
        alloc_store();
        allocs++;
      end
      for (int i = sq.size() - k; i < sq.size(); i++) begin
        if (pick_below(4) != 0) begin
          write_store_addr(i);
        end
      end
      for (int i = 0; i < 6; i++) begin
        random_load();
      end
      k = 1 + pick_below(sq.size());
      for (int i = 0; i < k; i++) begin
        commit_oldest();
      end
    end
    while (sq.size() != 0) begin
      commit_oldest();
    end
    finish_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/stq_pkg.sv
hdl/stq_alloc.sv
hdl/stq_entry_array.sv
hdl/stq_load_check.sv
hdl/stq_commit.sv
hdl/stq_top.sv
dv/stq_tb.sv
